//--- logic/int_core_cfg_pkg.sv
/*
 * Sizing constants of the integer wake-up and issue slice
 * and the physical register tag type derived from them
 */
`default_nettype none

package int_core_cfg_pkg;

  // Micro-ops accepted from dispatch in one cycle
  parameter int DISPATCH_WIDTH = 2;

  // Integer physical register file entries
  parameter int PRF_INT_SIZE = 32;

  // Write-back ports, one per issue way
  parameter int PRF_INT_WAYS = 2;

  // Issue-queue slots
  parameter int IQ_INT_SIZE = 8;

  // Cycles from issue to write-back
  parameter int EXEC_LATENCY = 3;

  // Width of the micro-op identifier
  parameter int UOP_ID_SIZE = 8;

  // Derived tag width
  parameter int PRF_TAG_WIDTH = $clog2(PRF_INT_SIZE);

  typedef logic [PRF_TAG_WIDTH-1:0] prf_tag_t;

endpackage

`default_nettype wire

//--- logic/int_uop_pkg.sv
/*
 * Micro-op record seen by dispatch, the issue queue and issue ports,
 * and the write-back record of the execution model
 */
`default_nettype none

package int_uop_pkg;

  // Renamed micro-op, identifier first
  typedef struct packed {
    logic [int_core_cfg_pkg::UOP_ID_SIZE-1:0] id;
    int_core_cfg_pkg::prf_tag_t               dest;
    int_core_cfg_pkg::prf_tag_t               rs1;
    int_core_cfg_pkg::prf_tag_t               rs2;
  } uop_t;

  // One write-back port entry
  typedef struct packed {
    logic                       valid;
    int_core_cfg_pkg::prf_tag_t dest;
  } wb_t;

endpackage

`default_nettype wire

//--- logic/iq_query_if.sv
/*
 * Per-slot source lookup between issue queue and scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

interface iq_query_if #(
  parameter int IQ_INT_SIZE = int_core_cfg_pkg::IQ_INT_SIZE
);
  import int_core_cfg_pkg::*;

  // Source tags of every slot, valid or not
  prf_tag_t [IQ_INT_SIZE-1:0] rs1_index;
  prf_tag_t [IQ_INT_SIZE-1:0] rs2_index;

  // Busy flags, write-back bypass already applied
  logic [IQ_INT_SIZE-1:0] rs1_busy;
  logic [IQ_INT_SIZE-1:0] rs2_busy;

  modport queue (output rs1_index, output rs2_index, input rs1_busy, input rs2_busy);

  modport board (input rs1_index, input rs2_index, output rs1_busy, output rs2_busy);

endinterface

`default_nettype wire

//--- logic/scoreboard_int.sv
/*
 * Banked busy table for the integer physical registers
 * Set on dispatch, clear on write-back, same-cycle clear bypass
 */
`timescale 1ns/1ps
`default_nettype none

module scoreboard_int #(
  parameter int DISPATCH_WIDTH = int_core_cfg_pkg::DISPATCH_WIDTH,
  parameter int PRF_INT_SIZE   = int_core_cfg_pkg::PRF_INT_SIZE,
  parameter int PRF_INT_WAYS   = int_core_cfg_pkg::PRF_INT_WAYS,
  parameter int IQ_INT_SIZE    = int_core_cfg_pkg::IQ_INT_SIZE
) (
  input  logic                                             clock,
  input  logic                                             arst_n,
  input  logic                                             flush,
  input  logic [DISPATCH_WIDTH-1:0]                        set_busy_valid,
  input  logic [DISPATCH_WIDTH-1:0][$clog2(PRF_INT_SIZE)-1:0] set_busy_index,
  input  logic [PRF_INT_WAYS-1:0]                          wb_valid,
  input  logic [PRF_INT_WAYS-1:0][$clog2(PRF_INT_SIZE)-1:0] wb_dest,
  iq_query_if.board                                        query
);

  // One copy of the busy vector per queue slot
  logic [PRF_INT_SIZE-1:0] busy_bank [IQ_INT_SIZE];

  logic [PRF_INT_SIZE-1:0] set_req;
  logic [PRF_INT_SIZE-1:0] clear_req;
  logic [IQ_INT_SIZE-1:0]  rs1_busy;
  logic [IQ_INT_SIZE-1:0]  rs2_busy;

  // Decode dispatch and write-back tags into bit masks
  always_comb begin
    set_req   = '0;
    clear_req = '0;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      if (set_busy_valid[l])
        set_req[set_busy_index[l]] = 1'b1;
    end
    for (int w = 0; w < PRF_INT_WAYS; w++) begin
      if (wb_valid[w])
        clear_req[wb_dest[w]] = 1'b1;
    end
  end

  // Lookup from the slot's own bank, a matching write-back wins
  always_comb begin
    for (int s = 0; s < IQ_INT_SIZE; s++) begin
      rs1_busy[s] = busy_bank[s][query.rs1_index[s]];
      rs2_busy[s] = busy_bank[s][query.rs2_index[s]];
      for (int w = 0; w < PRF_INT_WAYS; w++) begin
        if (wb_valid[w] && (wb_dest[w] == query.rs1_index[s]))
          rs1_busy[s] = 1'b0;
        if (wb_valid[w] && (wb_dest[w] == query.rs2_index[s]))
          rs2_busy[s] = 1'b0;
      end
    end
  end

  assign query.rs1_busy = rs1_busy;
  assign query.rs2_busy = rs2_busy;

  // Clear beats set for the same tag
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < IQ_INT_SIZE; s++)
        busy_bank[s] <= '0;
    end else if (flush) begin
      for (int s = 0; s < IQ_INT_SIZE; s++)
        busy_bank[s] <= '0;
    end else begin
      for (int s = 0; s < IQ_INT_SIZE; s++)
        busy_bank[s] <= (busy_bank[s] | set_req) & ~clear_req;
    end
  end

endmodule

`default_nettype wire

//--- logic/issue_queue_int.sv
/*
 * Integer issue queue: slot storage, dispatch allocation,
 * readiness from the scoreboard and lowest-index multi-way select
 */
`timescale 1ns/1ps
`default_nettype none

module issue_queue_int #(
  parameter int DISPATCH_WIDTH = int_core_cfg_pkg::DISPATCH_WIDTH,
  parameter int PRF_INT_SIZE   = int_core_cfg_pkg::PRF_INT_SIZE,
  parameter int PRF_INT_WAYS   = int_core_cfg_pkg::PRF_INT_WAYS,
  parameter int IQ_INT_SIZE    = int_core_cfg_pkg::IQ_INT_SIZE
) (
  input  logic                                              clock,
  input  logic                                              arst_n,
  input  logic                                              flush,
  input  logic [DISPATCH_WIDTH-1:0]                         disp_valid,
  input  int_uop_pkg::uop_t [DISPATCH_WIDTH-1:0]            disp_uop,
  output logic                                              disp_ready,
  output logic [DISPATCH_WIDTH-1:0]                         set_busy_valid,
  output logic [DISPATCH_WIDTH-1:0][$clog2(PRF_INT_SIZE)-1:0] set_busy_index,
  iq_query_if.queue                                         query,
  output logic [PRF_INT_WAYS-1:0]                           issue_valid,
  output int_uop_pkg::uop_t [PRF_INT_WAYS-1:0]              issue_uop
);
  import int_uop_pkg::*;

  localparam int LANE_W = (DISPATCH_WIDTH > 1) ? $clog2(DISPATCH_WIDTH) : 1;
  localparam int CNT_W  = $clog2(IQ_INT_SIZE + 1);

  logic [IQ_INT_SIZE-1:0]             slot_valid;
  uop_t                               slot_uop [IQ_INT_SIZE];
  logic [IQ_INT_SIZE-1:0]             alloc_we;
  logic [IQ_INT_SIZE-1:0][LANE_W-1:0] alloc_lane;
  logic [IQ_INT_SIZE-1:0]             eligible;
  logic [IQ_INT_SIZE-1:0]             issue_mask;
  logic [CNT_W-1:0]                   free_count;

  // Free slots counted at the start of the cycle
  always_comb begin
    free_count = '0;
    for (int s = 0; s < IQ_INT_SIZE; s++)
      free_count = free_count + CNT_W'(!slot_valid[s]);
  end

  assign disp_ready = (free_count >= CNT_W'(DISPATCH_WIDTH));

  // Lanes in order take the lowest free slots
  always_comb begin
    logic [IQ_INT_SIZE-1:0] avail;
    logic                   placed;
    avail      = ~slot_valid;
    alloc_we   = '0;
    alloc_lane = '0;
    placed     = 1'b0;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      placed = 1'b0;
      if (disp_valid[l] && disp_ready) begin
        for (int s = 0; s < IQ_INT_SIZE; s++) begin
          if (avail[s] && !placed) begin
            alloc_we[s]   = 1'b1;
            alloc_lane[s] = LANE_W'(l);
            avail[s]      = 1'b0;
            placed        = 1'b1;
          end
        end
      end
    end
  end

  // Dest tags of accepted lanes go busy at the edge
  always_comb begin
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      set_busy_valid[l] = disp_valid[l] && disp_ready;
      set_busy_index[l] = disp_uop[l].dest;
    end
  end

  for (genvar s = 0; s < IQ_INT_SIZE; s++) begin : g_query
    assign query.rs1_index[s] = slot_uop[s].rs1;
    assign query.rs2_index[s] = slot_uop[s].rs2;
  end

  // Nothing issues in a flush cycle
  assign eligible = slot_valid & ~query.rs1_busy & ~query.rs2_busy & {IQ_INT_SIZE{!flush}};

  // Each way takes the lowest eligible slot left over
  always_comb begin
    logic [IQ_INT_SIZE-1:0] remaining;
    remaining   = eligible;
    issue_mask  = '0;
    issue_valid = '0;
    issue_uop   = '0;
    for (int w = 0; w < PRF_INT_WAYS; w++) begin
      for (int s = 0; s < IQ_INT_SIZE; s++) begin
        if (remaining[s] && !issue_valid[w]) begin
          issue_valid[w] = 1'b1;
          issue_uop[w]   = slot_uop[s];
          issue_mask[s]  = 1'b1;
          remaining[s]   = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n)
      slot_valid <= '0;
    else if (flush)
      slot_valid <= '0;
    else
      slot_valid <= (slot_valid & ~issue_mask) | alloc_we;
  end

  // Slot payload
  always_ff @(posedge clock) begin
    for (int s = 0; s < IQ_INT_SIZE; s++) begin
      if (alloc_we[s])
        slot_uop[s] <= disp_uop[alloc_lane[s]];
    end
  end

endmodule

`default_nettype wire

//--- logic/int_exec_pipe.sv
/*
 * Fixed-latency model of the integer execution units
 * Returns each issued dest tag as a write-back
 */
`timescale 1ns/1ps
`default_nettype none

module int_exec_pipe #(
  parameter int PRF_INT_WAYS = int_core_cfg_pkg::PRF_INT_WAYS,
  parameter int EXEC_LATENCY = int_core_cfg_pkg::EXEC_LATENCY
) (
  input  logic                                         clock,
  input  logic                                         arst_n,
  input  logic                                         flush,
  input  logic [PRF_INT_WAYS-1:0]                      issue_valid,
  input  int_uop_pkg::uop_t [PRF_INT_WAYS-1:0]         issue_uop,
  output logic [PRF_INT_WAYS-1:0]                      wb_valid,
  output int_core_cfg_pkg::prf_tag_t [PRF_INT_WAYS-1:0] wb_dest
);
  import int_uop_pkg::*;

  // Stage 0 holds what issued in the previous cycle
  wb_t [PRF_INT_WAYS-1:0] stage [EXEC_LATENCY];
  wb_t [PRF_INT_WAYS-1:0] stage_in;

  always_comb begin
    for (int w = 0; w < PRF_INT_WAYS; w++) begin
      stage_in[w].valid = issue_valid[w];
      stage_in[w].dest  = issue_uop[w].dest;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < EXEC_LATENCY; k++)
        stage[k] <= '0;
    end else if (flush) begin
      for (int k = 0; k < EXEC_LATENCY; k++)
        stage[k] <= '0;
    end else begin
      stage[0] <= stage_in;
      for (int k = 1; k < EXEC_LATENCY; k++)
        stage[k] <= stage[k-1];
    end
  end

  // Last stage drives the write-back ports
  always_comb begin
    for (int w = 0; w < PRF_INT_WAYS; w++) begin
      wb_valid[w] = stage[EXEC_LATENCY-1][w].valid;
      wb_dest[w]  = stage[EXEC_LATENCY-1][w].dest;
    end
  end

endmodule

`default_nettype wire

//--- logic/int_issue_core.sv
/*
 * Integer wake-up and issue slice: issue queue, scoreboard
 * and execution model behind plain ports
 */
`timescale 1ns/1ps
`default_nettype none

module int_issue_core #(
  parameter int DISPATCH_WIDTH = int_core_cfg_pkg::DISPATCH_WIDTH,
  parameter int PRF_INT_SIZE   = int_core_cfg_pkg::PRF_INT_SIZE,
  parameter int PRF_INT_WAYS   = int_core_cfg_pkg::PRF_INT_WAYS,
  parameter int IQ_INT_SIZE    = int_core_cfg_pkg::IQ_INT_SIZE,
  parameter int EXEC_LATENCY   = int_core_cfg_pkg::EXEC_LATENCY
) (
  input  logic                                                       clock,
  input  logic                                                       arst_n,
  input  logic                                                       flush,
  input  logic [DISPATCH_WIDTH-1:0]                                  disp_valid,
  input  logic [DISPATCH_WIDTH-1:0][int_core_cfg_pkg::UOP_ID_SIZE-1:0] disp_id,
  input  int_core_cfg_pkg::prf_tag_t [DISPATCH_WIDTH-1:0]            disp_dest,
  input  int_core_cfg_pkg::prf_tag_t [DISPATCH_WIDTH-1:0]            disp_rs1,
  input  int_core_cfg_pkg::prf_tag_t [DISPATCH_WIDTH-1:0]            disp_rs2,
  output logic                                                       disp_ready,
  output logic [PRF_INT_WAYS-1:0]                                    issue_valid,
  output logic [PRF_INT_WAYS-1:0][int_core_cfg_pkg::UOP_ID_SIZE-1:0] issue_id,
  output int_core_cfg_pkg::prf_tag_t [PRF_INT_WAYS-1:0]              issue_dest,
  output logic [PRF_INT_WAYS-1:0]                                    wb_valid,
  output int_core_cfg_pkg::prf_tag_t [PRF_INT_WAYS-1:0]              wb_dest
);
  import int_uop_pkg::*;

  uop_t [DISPATCH_WIDTH-1:0]                          disp_uop;
  uop_t [PRF_INT_WAYS-1:0]                            issue_uop;
  logic [DISPATCH_WIDTH-1:0]                          set_busy_valid;
  logic [DISPATCH_WIDTH-1:0][$clog2(PRF_INT_SIZE)-1:0] set_busy_index;

  iq_query_if #(.IQ_INT_SIZE(IQ_INT_SIZE)) iq_query ();

  // Pack dispatch lanes, unpack issue ways
  always_comb begin
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      disp_uop[l].id   = disp_id[l];
      disp_uop[l].dest = disp_dest[l];
      disp_uop[l].rs1  = disp_rs1[l];
      disp_uop[l].rs2  = disp_rs2[l];
    end
    for (int w = 0; w < PRF_INT_WAYS; w++) begin
      issue_id[w]   = issue_uop[w].id;
      issue_dest[w] = issue_uop[w].dest;
    end
  end

  issue_queue_int #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .PRF_INT_SIZE   (PRF_INT_SIZE),
    .PRF_INT_WAYS   (PRF_INT_WAYS),
    .IQ_INT_SIZE    (IQ_INT_SIZE)
  ) u_issue_queue (
    .clock          (clock),
    .arst_n         (arst_n),
    .flush          (flush),
    .disp_valid     (disp_valid),
    .disp_uop       (disp_uop),
    .disp_ready     (disp_ready),
    .set_busy_valid (set_busy_valid),
    .set_busy_index (set_busy_index),
    .query          (iq_query.queue),
    .issue_valid    (issue_valid),
    .issue_uop      (issue_uop)
  );

  scoreboard_int #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .PRF_INT_SIZE   (PRF_INT_SIZE),
    .PRF_INT_WAYS   (PRF_INT_WAYS),
    .IQ_INT_SIZE    (IQ_INT_SIZE)
  ) u_scoreboard (
    .clock          (clock),
    .arst_n         (arst_n),
    .flush          (flush),
    .set_busy_valid (set_busy_valid),
    .set_busy_index (set_busy_index),
    .wb_valid       (wb_valid),
    .wb_dest        (wb_dest),
    .query          (iq_query.board)
  );

  int_exec_pipe #(
    .PRF_INT_WAYS (PRF_INT_WAYS),
    .EXEC_LATENCY (EXEC_LATENCY)
  ) u_exec_pipe (
    .clock       (clock),
    .arst_n      (arst_n),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest)
  );

endmodule

`default_nettype wire

//--- verif/int_issue_checker.sv
/*
 * Watches the issue slice ports with a reference busy set, waiting micro-ops,
 * expected write-backs and the dispatch back-pressure rule
 */
`timescale 1ns/1ps
`default_nettype none

module int_issue_checker #(
  parameter int DISPATCH_WIDTH = int_core_cfg_pkg::DISPATCH_WIDTH,
  parameter int PRF_INT_SIZE   = int_core_cfg_pkg::PRF_INT_SIZE,
  parameter int PRF_INT_WAYS   = int_core_cfg_pkg::PRF_INT_WAYS,
  parameter int IQ_INT_SIZE    = int_core_cfg_pkg::IQ_INT_SIZE,
  parameter int EXEC_LATENCY   = int_core_cfg_pkg::EXEC_LATENCY
) (
  input  logic                                                       clock,
  input  logic                                                       arst_n,
  input  logic                                                       flush,
  input  logic [DISPATCH_WIDTH-1:0]                                  disp_valid,
  input  logic [DISPATCH_WIDTH-1:0][int_core_cfg_pkg::UOP_ID_SIZE-1:0] disp_id,
  input  int_core_cfg_pkg::prf_tag_t [DISPATCH_WIDTH-1:0]            disp_dest,
  input  int_core_cfg_pkg::prf_tag_t [DISPATCH_WIDTH-1:0]            disp_rs1,
  input  int_core_cfg_pkg::prf_tag_t [DISPATCH_WIDTH-1:0]            disp_rs2,
  input  logic                                                       disp_ready,
  input  logic [PRF_INT_WAYS-1:0]                                    issue_valid,
  input  logic [PRF_INT_WAYS-1:0][int_core_cfg_pkg::UOP_ID_SIZE-1:0] issue_id,
  input  int_core_cfg_pkg::prf_tag_t [PRF_INT_WAYS-1:0]              issue_dest,
  input  logic [PRF_INT_WAYS-1:0]                                    wb_valid,
  input  int_core_cfg_pkg::prf_tag_t [PRF_INT_WAYS-1:0]              wb_dest,
  output int                                                         errors
);
  import int_core_cfg_pkg::*;

  localparam int ID_COUNT = 2 ** UOP_ID_SIZE;

  string test_name = "none";

  // Reference busy set and the waiting micro-ops indexed by id
  logic [PRF_INT_SIZE-1:0]     busy;
  logic                        wait_valid [ID_COUNT];
  prf_tag_t                    wait_dest [ID_COUNT];
  prf_tag_t                    wait_rs1 [ID_COUNT];
  prf_tag_t                    wait_rs2 [ID_COUNT];
  logic [PRF_INT_WAYS-1:0]     exp_valid [EXEC_LATENCY];
  prf_tag_t [PRF_INT_WAYS-1:0] exp_dest [EXEC_LATENCY];

  // A source is ready when not busy or written back in this same cycle
  function automatic logic src_ready(input logic [PRF_INT_SIZE-1:0] busy_set,
                                     input logic [PRF_INT_WAYS-1:0] wbv,
                                     input prf_tag_t [PRF_INT_WAYS-1:0] wbd,
                                     input prf_tag_t tag);
    logic ready;
    ready = !busy_set[tag];
    for (int w = 0; w < PRF_INT_WAYS; w++) begin
      if (wbv[w] && (wbd[w] == tag))
        ready = 1'b1;
    end
    return ready;
  endfunction

  task automatic flag_mismatch(input string what, input int expected, input int actual);
    errors++;
    $display("MISMATCH %s: %s expected %0d actual %0d", test_name, what, expected, actual);
  endtask

  task automatic clear_state();
    busy = '0;
    for (int i = 0; i < ID_COUNT; i++)
      wait_valid[i] = 1'b0;
    for (int k = 0; k < EXEC_LATENCY; k++) begin
      exp_valid[k] = '0;
      exp_dest[k]  = '0;
    end
  endtask

  always @(posedge clock or negedge arst_n) begin
    logic exp_ready;
    int   occupied;
    int   issued;
    int   id;
    if (!arst_n) begin
      clear_state();
    end else if (flush) begin
      clear_state();
    end else begin
      occupied = 0;
      for (int i = 0; i < ID_COUNT; i++)
        occupied += wait_valid[i];
      exp_ready = (IQ_INT_SIZE - occupied) >= DISPATCH_WIDTH;
      if (disp_ready !== exp_ready)
        flag_mismatch("disp_ready", exp_ready, disp_ready);
      for (int w = 0; w < PRF_INT_WAYS; w++) begin
        if (wb_valid[w] !== exp_valid[EXEC_LATENCY-1][w])
          flag_mismatch($sformatf("wb_valid way %0d", w), exp_valid[EXEC_LATENCY-1][w],
                        wb_valid[w]);
        else if (wb_valid[w] && (wb_dest[w] !== exp_dest[EXEC_LATENCY-1][w]))
          flag_mismatch($sformatf("wb_dest way %0d", w), exp_dest[EXEC_LATENCY-1][w],
                        wb_dest[w]);
      end
      issued = 0;
      for (int w = 0; w < PRF_INT_WAYS; w++) begin
        if (issue_valid[w]) begin
          issued++;
          id = issue_id[w];
          if (!wait_valid[id]) begin
            errors++;
            $display("Error in %s: id %0d issued but was not waiting in the queue",
                     test_name, id);
          end else begin
            if (!src_ready(busy, wb_valid, wb_dest, wait_rs1[id]) ||
                !src_ready(busy, wb_valid, wb_dest, wait_rs2[id]))
              flag_mismatch($sformatf("issue of id %0d with a busy source", id), 0, 1);
            if (issue_dest[w] !== wait_dest[id])
              flag_mismatch($sformatf("issue_dest of id %0d", id), wait_dest[id],
                            issue_dest[w]);
            wait_valid[id] = 1'b0;
          end
        end
      end
      // A free way left while a ready micro-op waits means a lost wake-up
      if (issued < PRF_INT_WAYS) begin
        for (int i = 0; i < ID_COUNT; i++) begin
          if (wait_valid[i] && src_ready(busy, wb_valid, wb_dest, wait_rs1[i]) &&
              src_ready(busy, wb_valid, wb_dest, wait_rs2[i]))
            flag_mismatch($sformatf("issue of ready id %0d", i), 1, 0);
        end
      end
      for (int k = EXEC_LATENCY - 1; k > 0; k--) begin
        exp_valid[k] = exp_valid[k-1];
        exp_dest[k]  = exp_dest[k-1];
      end
      exp_valid[0] = issue_valid;
      exp_dest[0]  = issue_dest;
      for (int l = 0; l < DISPATCH_WIDTH; l++) begin
        if (disp_valid[l] && disp_ready) begin
          busy[disp_dest[l]]     = 1'b1;
          wait_valid[disp_id[l]] = 1'b1;
          wait_dest[disp_id[l]]  = disp_dest[l];
          wait_rs1[disp_id[l]]   = disp_rs1[l];
          wait_rs2[disp_id[l]]   = disp_rs2[l];
        end
      end
      // Clear after set so a write-back wins for the same tag
      for (int w = 0; w < PRF_INT_WAYS; w++) begin
        if (wb_valid[w])
          busy[wb_dest[w]] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/int_issue_core_tb.sv
/*
 * Integer issue slice testbench with clock, reset, dispatch
 * stimulus with tag bookkeeping, timeout and final report
 */
`timescale 1ns/1ps
`default_nettype none

module int_issue_core_tb;
  import int_core_cfg_pkg::*;

  // Micro-ops per test in the order the tests run
  localparam int UOP_TOTAL   = 24 + 6 + 64 + 14 + 300;
  localparam int CYCLE_LIMIT = 20 + UOP_TOTAL * (EXEC_LATENCY + 1) + 200;

  logic                                       clock = 1'b0;
  logic                                       arst_n;
  logic                                       flush;
  logic [DISPATCH_WIDTH-1:0]                  disp_valid;
  logic [DISPATCH_WIDTH-1:0][UOP_ID_SIZE-1:0] disp_id;
  prf_tag_t [DISPATCH_WIDTH-1:0]              disp_dest;
  prf_tag_t [DISPATCH_WIDTH-1:0]              disp_rs1;
  prf_tag_t [DISPATCH_WIDTH-1:0]              disp_rs2;
  logic                                       disp_ready;
  logic [PRF_INT_WAYS-1:0]                    issue_valid;
  logic [PRF_INT_WAYS-1:0][UOP_ID_SIZE-1:0]   issue_id;
  prf_tag_t [PRF_INT_WAYS-1:0]                issue_dest;
  logic [PRF_INT_WAYS-1:0]                    wb_valid;
  prf_tag_t [PRF_INT_WAYS-1:0]                wb_dest;
  int                                         errors;

  // Tags in flight and count of waiting readers per tag
  logic [PRF_INT_SIZE-1:0] in_flight;
  int                      reader_count [PRF_INT_SIZE];
  prf_tag_t                id_rs1 [2**UOP_ID_SIZE];
  prf_tag_t                id_rs2 [2**UOP_ID_SIZE];
  int                      outstanding;
  logic                    last_accept;
  logic [UOP_ID_SIZE-1:0]  next_id;
  integer                  seed = 32'h817a1f29;
  int                      cycle_count;
  int                      tests_run;
  int                      tests_failed;
  int                      errors_before;
  int                      local_errors;

  // Cycles with disp_ready low
  int                      stall_cycles;
  int                      stall_base;

  always #2 clock = ~clock;

  int_issue_core #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .PRF_INT_SIZE   (PRF_INT_SIZE),
    .PRF_INT_WAYS   (PRF_INT_WAYS),
    .IQ_INT_SIZE    (IQ_INT_SIZE),
    .EXEC_LATENCY   (EXEC_LATENCY)
  ) uut (
    .clock(clock), .arst_n(arst_n), .flush(flush),
    .disp_valid(disp_valid), .disp_id(disp_id), .disp_dest(disp_dest),
    .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_ready(disp_ready),
    .issue_valid(issue_valid), .issue_id(issue_id), .issue_dest(issue_dest),
    .wb_valid(wb_valid), .wb_dest(wb_dest)
  );

  int_issue_checker #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .PRF_INT_SIZE   (PRF_INT_SIZE),
    .PRF_INT_WAYS   (PRF_INT_WAYS),
    .IQ_INT_SIZE    (IQ_INT_SIZE),
    .EXEC_LATENCY   (EXEC_LATENCY)
  ) chk (
    .clock(clock), .arst_n(arst_n), .flush(flush),
    .disp_valid(disp_valid), .disp_id(disp_id), .disp_dest(disp_dest),
    .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_ready(disp_ready),
    .issue_valid(issue_valid), .issue_id(issue_id), .issue_dest(issue_dest),
    .wb_valid(wb_valid), .wb_dest(wb_dest), .errors(errors)
  );

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n || flush) begin
      in_flight   = '0;
      outstanding = 0;
      last_accept = 1'b0;
      for (int t = 0; t < PRF_INT_SIZE; t++)
        reader_count[t] = 0;
    end else begin
      last_accept = disp_ready;
      if (!disp_ready)
        stall_cycles++;
      for (int w = 0; w < PRF_INT_WAYS; w++) begin
        if (issue_valid[w]) begin
          reader_count[id_rs1[issue_id[w]]]--;
          reader_count[id_rs2[issue_id[w]]]--;
        end
      end
      for (int l = 0; l < DISPATCH_WIDTH; l++) begin
        if (disp_valid[l] && disp_ready) begin
          in_flight[disp_dest[l]] = 1'b1;
          reader_count[disp_rs1[l]]++;
          reader_count[disp_rs2[l]]++;
          id_rs1[disp_id[l]] = disp_rs1[l];
          id_rs2[disp_id[l]] = disp_rs2[l];
          outstanding++;
        end
      end
      for (int w = 0; w < PRF_INT_WAYS; w++) begin
        if (wb_valid[w]) begin
          in_flight[wb_dest[w]] = 1'b0;
          outstanding--;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d micro-ops not written back",
               cycle_count, outstanding);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int find_tag(input logic [PRF_INT_SIZE-1:0] allowed, input int start);
    for (int i = 0; i < PRF_INT_SIZE; i++) begin
      if (allowed[(start + i) % PRF_INT_SIZE])
        return (start + i) % PRF_INT_SIZE;
    end
    return -1;
  endfunction

  // Dependent sources come from tags in flight or lower lanes' dests
  function automatic prf_tag_t pick_source(input int dest, input logic dep,
                                           input logic [PRF_INT_SIZE-1:0] lower_dests);
    logic [PRF_INT_SIZE-1:0] pool;
    int                      t;
    pool       = dep ? (in_flight | lower_dests) : ~(in_flight | lower_dests);
    pool[dest] = 1'b0;
    t = find_tag(pool, rand_below(PRF_INT_SIZE));
    if (t < 0)
      t = (dest + 1) % PRF_INT_SIZE;
    return prf_tag_t'(t);
  endfunction

  task automatic wait_accept();
    @(posedge clock);
    #1;
    while (!last_accept) begin
      @(posedge clock);
      #1;
    end
  endtask

  // A dest is free when not in flight and read by no waiting micro-op
  task automatic fill_lanes(input int left, input int valid_pct, input int dep_pct,
                            output int n);
    logic [PRF_INT_SIZE-1:0] free_mask;
    logic [PRF_INT_SIZE-1:0] taken;
    logic [PRF_INT_SIZE-1:0] lower_dests;
    int                      d;
    n           = 0;
    taken       = '0;
    lower_dests = '0;
    for (int t = 0; t < PRF_INT_SIZE; t++)
      free_mask[t] = !in_flight[t] && (reader_count[t] == 0);
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      disp_valid[l] = 1'b0;
      d = find_tag(free_mask & ~taken, rand_below(PRF_INT_SIZE));
      if ((n < left) && (rand_below(100) < valid_pct) && (d >= 0)) begin
        disp_valid[l] = 1'b1;
        disp_id[l]    = next_id;
        disp_dest[l]  = prf_tag_t'(d);
        disp_rs1[l]   = pick_source(d, rand_below(100) < dep_pct, lower_dests);
        disp_rs2[l]   = pick_source(d, rand_below(100) < dep_pct, lower_dests);
        taken[d]            = 1'b1;
        taken[disp_rs1[l]]  = 1'b1;
        taken[disp_rs2[l]]  = 1'b1;
        lower_dests[d]      = 1'b1;
        next_id = next_id + 1'b1;
        n++;
      end
    end
  endtask

  task automatic run_stream(input int total, input int valid_pct, input int dep_pct);
    int sent;
    int n;
    sent = 0;
    while (sent < total) begin
      fill_lanes(total - sent, valid_pct, dep_pct, n);
      wait_accept();
      sent += n;
    end
    disp_valid = '0;
  endtask

  task automatic send_one(input prf_tag_t dest, input prf_tag_t rs1, input prf_tag_t rs2);
    disp_valid    = '0;
    disp_valid[0] = 1'b1;
    disp_id[0]    = next_id;
    disp_dest[0]  = dest;
    disp_rs1[0]   = rs1;
    disp_rs2[0]   = rs2;
    next_id       = next_id + 1'b1;
    wait_accept();
    disp_valid = '0;
  endtask

  task automatic wait_drain();
    while (outstanding != 0) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic start_test(input string name);
    chk.test_name = name;
  endtask

  task automatic end_test(input string name);
    int delta;
    delta = errors + local_errors - errors_before;
    tests_run++;
    if (delta != 0)
      tests_failed++;
    $display("test %s %s, %0d errors", name, (delta == 0) ? "ok" : "bad", delta);
    errors_before = errors + local_errors;
  endtask

  initial begin
    arst_n     = 1'b0;
    flush      = 1'b0;
    disp_valid = '0;
    disp_id    = '0;
    disp_dest  = '0;
    disp_rs1   = '0;
    disp_rs2   = '0;
    next_id    = '0;
    repeat (3) @(posedge clock);
    #1;
    arst_n = 1'b1;

    start_test("reset");
    repeat (10) begin
      @(posedge clock);
      #1;
    end
    end_test("reset");

    start_test("independent");
    run_stream(24, 100, 0);
    wait_drain();
    end_test("independent");

    // Each link reads the previous dest and tag 9 starts out ready
    start_test("chain");
    for (int i = 0; i < 6; i++)
      send_one(prf_tag_t'(10 + i), prf_tag_t'(9 + i), prf_tag_t'(9 + i));
    wait_drain();
    end_test("chain");

    start_test("backpressure");
    stall_base = stall_cycles;
    run_stream(64, 100, 70);
    wait_drain();
    if (stall_cycles == stall_base) begin
      local_errors++;
      $display("Error in backpressure: the queue never filled and disp_ready stayed high");
    end
    end_test("backpressure");

    start_test("flush");
    run_stream(12, 100, 80);
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
    repeat (EXEC_LATENCY + 2) begin
      @(posedge clock);
      #1;
    end
    send_one(prf_tag_t'(20), prf_tag_t'(3), prf_tag_t'(4));
    send_one(prf_tag_t'(21), prf_tag_t'(20), prf_tag_t'(3));
    wait_drain();
    end_test("flush");

    start_test("random_mix");
    run_stream(300, 70, 50);
    wait_drain();
    end_test("random_mix");

    $display("tests %0d, failed %0d, checker errors %0d, testbench errors %0d",
             tests_run, tests_failed, errors, local_errors);
    if ((errors == 0) && (local_errors == 0) && (tests_failed == 0))
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- int_issue_core.f
logic/int_core_cfg_pkg.sv
logic/int_uop_pkg.sv
logic/iq_query_if.sv
logic/scoreboard_int.sv
logic/issue_queue_int.sv
logic/int_exec_pipe.sv
logic/int_issue_core.sv
verif/int_issue_checker.sv
verif/int_issue_core_tb.sv
